//--- filelist.f
source/leaf_pkg.sv
source/leaf_stream_fifo.sv
source/leaf_rx_demux.sv
source/user_kernel.sv
source/leaf_tx_arbiter.sv
source/leaf_i3o2.sv
tb/tb_leaf_i3o2.sv

//--- tb/tb_leaf_i3o2.sv
`default_nettype none

module tb_leaf_i3o2
    import leaf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TB_LEAF    = 3;
    localparam int          NUM_FLITS  = 800;
    localparam int          WD_CYCLES  = 40 * (NUM_FLITS + 2) + 2000;
    localparam logic [31:0] SEED       = 32'd90139;
    localparam logic [31:0] LFSR_TAPS  = 32'hB4BC_D35C;

    logic  clk;
    logic  rst_n;
    logic  resend;
    flit_t din;
    flit_t dout;

    logic [31:0]  lfsr_q;
    int           res_left;
    route_t       route_m [NUM_OUT_PORTS];
    addr_t        seq_m [NUM_OUT_PORTS];
    payload_t     acc_m;
    payload_t     pend1_q[$];
    payload_t     pend2_q[$];
    payload_t     exp1_q[$];
    payload_t     exp2_q[$];

    leaf_i3o2 #(.LEAF_ID(TB_LEAF)) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (din),
        .resend(resend),
        .dout  (dout)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Random stretches, short high and longer low
    task automatic step_resend();
        logic [31:0] r;
        if (res_left > 0) begin
            res_left = res_left - 1;
        end else begin
            resend = !resend;
            random_bits(5, r);
            res_left = resend ? int'(r[3:0]) : 8 + int'(r[4:0]);
        end
    endtask

    task automatic send_slot(input flit_t f);
        @(negedge clk);
        step_resend();
        din = f;
        repeat (3) begin
            @(negedge clk);
            step_resend();
            din = '0;
        end
    endtask

    // Reference model of the kernel
    task automatic model_accept(input port_t p, input payload_t w);
        if (p == 4'd1) begin
            pend1_q.push_back(w);
        end else if (p == 4'd2) begin
            pend2_q.push_back(w);
        end else begin
            acc_m = acc_m + w;
            exp2_q.push_back(acc_m);
        end
        if (pend1_q.size() > 0 && pend2_q.size() > 0) begin
            exp1_q.push_back(pend1_q.pop_front() + pend2_q.pop_front());
        end
    endtask

    task automatic make_flit(output flit_t f);
        logic [31:0] kind;
        logic [31:0] word;
        logic [31:0] extra;
        random_bits(3, kind);
        random_bits(32, word);
        random_bits(7, extra);
        f.vld     = 1'b1;
        f.leaf    = leaf_t'(TB_LEAF);
        f.addr    = extra[6:0];
        f.payload = word;
        if (kind >= 6) begin
            random_bits(5, extra);
            f.port = 4'd1;
            case (extra[1:0])
                2'd0:    f.leaf = leaf_t'(TB_LEAF) + leaf_t'(1 + extra[4:2]);
                2'd1:    f.vld = 1'b0;
                default: f.port = 4'd4 + port_t'(extra[4:2]);
            endcase
        end else begin
            f.port = port_t'(kind[2:1] + 1);
            // Keep the unpaired backlog well under the FIFO depth
            if (f.port == 4'd1 && pend1_q.size() >= 12) f.port = 4'd2;
            else if (f.port == 4'd2 && pend2_q.size() >= 12) f.port = 4'd1;
            model_accept(f.port, f.payload);
        end
    endtask

    task automatic record_flit(input flit_t f);
        int       idx;
        payload_t exp;
        idx = 0;
        exp = '0;
        if (f.port == route_m[0].port) idx = 0;
        else if (f.port == route_m[1].port) idx = 1;
        else report_failure("Outgoing flit has a destination port of no route");
        if (idx == 0) begin
            if (exp1_q.size() == 0) report_failure("Extra flit on output 1");
            exp = exp1_q.pop_front();
        end else begin
            if (exp2_q.size() == 0) report_failure("Extra flit on output 2");
            exp = exp2_q.pop_front();
        end
        check_value("dout.leaf", 64'(f.leaf), 64'(route_m[idx].leaf));
        check_value("dout.addr", 64'(f.addr), 64'(seq_m[idx]));
        check_value("dout.payload", 64'(f.payload), 64'(exp));
        seq_m[idx] = seq_m[idx] + 1'b1;
    endtask

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (resend) check_value("dout", 64'(dout), 64'd0);
            else if (dout.vld) record_flit(dout);
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout, expected flits never left the leaf");
        $display("Finished with errors");
        $fatal(1);
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        flit_t       f;
        logic [31:0] r;
        clk      = 1'b0;
        rst_n    = 1'b0;
        resend   = 1'b0;
        din      = '0;
        lfsr_q   = SEED;
        res_left = 4;
        acc_m    = '0;
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            seq_m[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Distinct destination ports keep the outputs apart
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            random_bits(5, r);
            route_m[i].leaf = r[4:0];
            route_m[i].port = (i == 0) ? 4'h5 : 4'hA;
            f         = '0;
            f.vld     = 1'b1;
            f.leaf    = leaf_t'(TB_LEAF);
            f.port    = port_t'(CFG_PORT);
            f.payload = payload_t'({1'(i), route_m[i].port, route_m[i].leaf});
            send_slot(f);
        end

        for (int k = 0; k < NUM_FLITS; k++) begin
            make_flit(f);
            send_slot(f);
        end
        @(negedge clk);
        resend = 1'b0;

        while (exp1_q.size() != 0 || exp2_q.size() != 0) @(posedge clk);
        repeat (50) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/leaf_i3o2.sv
`default_nettype none

module leaf_i3o2
    import leaf_pkg::*;
#(
    parameter int unsigned LEAF_ID = 0
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire flit_t din,
    input  wire logic  resend,
    output flit_t      dout
);

    logic [NUM_IN_PORTS-1:0]           rx_push;
    payload_t                          rx_word;
    cfg_write_t                        rx_cfg;

    logic [NUM_IN_PORTS-1:0]           in_empty;
    logic [NUM_IN_PORTS-1:0]           in_pop;
    payload_t [NUM_IN_PORTS-1:0]       in_word;

    logic [NUM_OUT_PORTS-1:0]          res_push;
    payload_t [NUM_OUT_PORTS-1:0]      res_word;
    logic [NUM_OUT_PORTS-1:0]          out_empty;
    logic [NUM_OUT_PORTS-1:0]          out_full;
    logic [NUM_OUT_PORTS-1:0]          out_pop;
    payload_t [NUM_OUT_PORTS-1:0]      out_word;

    // ----------------------------------------
    // Receive side
    // ----------------------------------------
    leaf_rx_demux #(
        .LEAF_ID(LEAF_ID)
    ) u_rx_demux (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (din),
        .push (rx_push),
        .word (rx_word),
        .cfg  (rx_cfg)
    );

    // A full input FIFO drops the word
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in_fifo
        leaf_stream_fifo #(
            .entry_t(payload_t),
            .DEPTH  (FIFO_DEPTH)
        ) u_fifo (
            .clk  (clk),
            .rst_n(rst_n),
            .push (rx_push[i]),
            .wdata(rx_word),
            .pop  (in_pop[i]),
            .rdata(in_word[i]),
            .empty(in_empty[i]),
            .full ()
        );
    end

    // ----------------------------------------
    // Kernel
    // ----------------------------------------
    user_kernel u_kernel (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_empty(in_empty),
        .in_word (in_word),
        .in_pop  (in_pop),
        .out_full(out_full),
        .out_push(res_push),
        .out_word(res_word)
    );

    // ----------------------------------------
    // Transmit side
    // ----------------------------------------
    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_out_fifo
        leaf_stream_fifo #(
            .entry_t(payload_t),
            .DEPTH  (FIFO_DEPTH)
        ) u_fifo (
            .clk  (clk),
            .rst_n(rst_n),
            .push (res_push[j]),
            .wdata(res_word[j]),
            .pop  (out_pop[j]),
            .rdata(out_word[j]),
            .empty(out_empty[j]),
            .full (out_full[j])
        );
    end

    leaf_tx_arbiter u_tx_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (rx_cfg),
        .out_empty(out_empty),
        .out_word (out_word),
        .out_pop  (out_pop),
        .resend   (resend),
        .dout     (dout)
    );

endmodule

`default_nettype wire

//--- source/leaf_tx_arbiter.sv
`default_nettype none

module leaf_tx_arbiter
    import leaf_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire cfg_write_t                  cfg,
    input  wire logic [NUM_OUT_PORTS-1:0]    out_empty,
    input  wire payload_t [NUM_OUT_PORTS-1:0] out_word,
    output logic [NUM_OUT_PORTS-1:0]         out_pop,
    input  wire logic                        resend,
    output flit_t                            dout
);

    route_t [NUM_OUT_PORTS-1:0] route_q;
    addr_t  [NUM_OUT_PORTS-1:0] seq_q;
    logic                       last_q;
    logic [NUM_OUT_PORTS-1:0]   grant;
    logic                       gsel;
    flit_t                      flit_q;

    // ----------------------------------------
    // Round robin between the two outputs
    // ----------------------------------------
    // last_q set means output 2 went last
    always_comb begin
        grant = '0;
        if (!resend) begin
            if (!out_empty[0] && (out_empty[1] || last_q)) begin
                grant[0] = 1'b1;
            end else if (!out_empty[1]) begin
                grant[1] = 1'b1;
            end
        end
    end

    assign gsel    = grant[1];
    assign out_pop = grant;

    // ----------------------------------------
    // Route table, counters and flit register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_q <= '0;
            seq_q   <= '0;
            last_q  <= 1'b0;
            flit_q  <= '0;
        end else begin
            if (cfg.strobe) begin
                route_q[cfg.sel] <= cfg.route;
            end
            // Registered flit stays put while resend is high
            if (!resend) begin
                if (|grant) begin
                    flit_q.vld     <= 1'b1;
                    flit_q.leaf    <= route_q[gsel].leaf;
                    flit_q.port    <= route_q[gsel].port;
                    flit_q.addr    <= seq_q[gsel];
                    flit_q.payload <= out_word[gsel];
                    seq_q[gsel]    <= seq_q[gsel] + 1'b1;
                    last_q         <= gsel;
                end else begin
                    flit_q <= '0;
                end
            end
        end
    end

    // Tree sees nothing while it asks for a resend
    assign dout = resend ? '0 : flit_q;

endmodule

`default_nettype wire

//--- source/user_kernel.sv
`default_nettype none

module user_kernel
    import leaf_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [NUM_IN_PORTS-1:0]   in_empty,
    input  wire payload_t [NUM_IN_PORTS-1:0] in_word,
    output logic [NUM_IN_PORTS-1:0]        in_pop,
    input  wire logic [NUM_OUT_PORTS-1:0]  out_full,
    output logic [NUM_OUT_PORTS-1:0]       out_push,
    output payload_t [NUM_OUT_PORTS-1:0]   out_word
);

    logic [NUM_OUT_PORTS-1:0] push_q;
    logic                     fire_sum;
    logic                     fire_acc;
    payload_t                 acc_q;
    payload_t                 acc_next;
    payload_t                 pair_sum;

    // ----------------------------------------
    // Fire conditions
    // ----------------------------------------
    // Wait out a push in flight so full is current
    assign fire_sum = !in_empty[0] && !in_empty[1]
                   && !out_full[0] && !push_q[0];

    assign fire_acc = !in_empty[2] && !out_full[1] && !push_q[1];

    // Inputs 1 and 2 are consumed as a pair
    assign in_pop[0] = fire_sum;
    assign in_pop[1] = fire_sum;
    assign in_pop[2] = fire_acc;

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    assign pair_sum = in_word[0] + in_word[1];
    assign acc_next = acc_q + in_word[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_q <= '0;
            acc_q  <= '0;
        end else begin
            push_q[0] <= fire_sum;
            push_q[1] <= fire_acc;
            if (fire_acc) begin
                acc_q <= acc_next;
            end
        end
    end

    // Result registers, valid while the push strobe is high
    always_ff @(posedge clk) begin
        if (fire_sum) begin
            out_word[0] <= pair_sum;
        end
        if (fire_acc) begin
            out_word[1] <= acc_next;
        end
    end

    assign out_push = push_q;

endmodule

`default_nettype wire

//--- source/leaf_rx_demux.sv
`default_nettype none

module leaf_rx_demux
    import leaf_pkg::*;
#(
    parameter int unsigned LEAF_ID = 0
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire flit_t              din,
    output logic [NUM_IN_PORTS-1:0] push,
    output payload_t                word,
    output cfg_write_t              cfg
);

    flit_t                   flit_q;
    logic                    accept;
    logic [NUM_IN_PORTS-1:0] push_d;
    cfg_write_t              cfg_d;

    // ----------------------------------------
    // Stage 1, capture from the tree
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_q <= '0;
        end else begin
            flit_q <= din;
        end
    end

    // Addressed to us and on a port we serve
    assign accept = flit_q.vld
                 && (flit_q.leaf == leaf_t'(LEAF_ID))
                 && (flit_q.port <= port_t'(NUM_IN_PORTS));

    always_comb begin
        push_d = '0;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            push_d[i] = accept && (flit_q.port == port_t'(i + 1));
        end
    end

    // Route table write decode
    always_comb begin
        cfg_d            = '0;
        cfg_d.strobe     = accept && (flit_q.port == port_t'(CFG_PORT));
        cfg_d.sel        = flit_q.payload[CFG_SEL_BIT];
        cfg_d.route.leaf = flit_q.payload[CFG_LEAF_LSB +: LEAF_BITS];
        cfg_d.route.port = flit_q.payload[CFG_PORT_LSB +: PORT_BITS];
    end

    // ----------------------------------------
    // Stage 2, filtered strobes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= '0;
            cfg  <= '0;
        end else begin
            push <= push_d;
            cfg  <= cfg_d;
        end
    end

    // Same word goes to every input FIFO, push picks the one
    always_ff @(posedge clk) begin
        word <= flit_q.payload;
    end

endmodule

`default_nettype wire

//--- source/leaf_stream_fifo.sv
`default_nettype none

module leaf_stream_fifo
    import leaf_pkg::*;
#(
    parameter type entry_t = payload_t,
    parameter int  DEPTH   = FIFO_DEPTH
) (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   push,
    input  wire entry_t wdata,
    input  wire logic   pop,
    output entry_t      rdata,
    output logic        empty,
    output logic        full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    entry_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign empty = (count == '0);
    assign full  = (count == (PTR_BITS + 1)'(DEPTH));

    // Push on full and pop on empty are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head word shown without a read cycle
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- source/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    // ----------------------------------------
    // Flit geometry
    // ----------------------------------------
    localparam int FLIT_BITS = 49;
    localparam int LEAF_BITS = 5;
    localparam int PORT_BITS = 4;
    localparam int ADDR_BITS = 7;

    // Whatever is left after vld, leaf, port and addr
    localparam int PAYLOAD_BITS = FLIT_BITS - 1 - LEAF_BITS - PORT_BITS - ADDR_BITS;

    // ----------------------------------------
    // Leaf configuration
    // ----------------------------------------
    localparam int NUM_IN_PORTS  = 3;
    localparam int NUM_OUT_PORTS = 2;
    localparam int FIFO_DEPTH    = 16;

    // Port 0 carries route table writes
    localparam int CFG_PORT = 0;

    // Field positions inside a configuration payload
    localparam int CFG_LEAF_LSB = 0;
    localparam int CFG_PORT_LSB = 5;
    localparam int CFG_SEL_BIT  = 9;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [LEAF_BITS-1:0]    leaf_t;
    typedef logic [PORT_BITS-1:0]    port_t;
    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;

    // One packet on the tree, vld at the top bit
    typedef struct packed {
        logic     vld;
        leaf_t    leaf;
        port_t    port;
        addr_t    addr;
        payload_t payload;
    } flit_t;

    // Destination of one output stream
    typedef struct packed {
        leaf_t leaf;
        port_t port;
    } route_t;

    // Route table update, sel picks output 1 or 2
    typedef struct packed {
        logic   strobe;
        logic   sel;
        route_t route;
    } cfg_write_t;

endpackage

`default_nettype wire
